// ==== build.f ====
source/noc_pkg.sv
source/noc_input_unit.sv
source/noc_rr_arbiter.sv
source/noc_switch_control.sv
source/noc_crossbar.sv
source/noc_router_top.sv
sim/tb_noc_router.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the router testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_noc_router -f build.f -o sim_noc \
  && ./obj_dir/sim_noc | tee sim.log \
  || { echo "Build or run of the simulation failed"; exit 1; }
grep -q "TEST OK" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_noc_router.sv ====
/*
  Directed testbench for the four-port wormhole router. Sends packets on the
  input links, collects what leaves on each output and compares the output
  streams packet by packet. Prints one summary line at the end.
*/

`timescale 1ns/100ps

module tb_noc_router;

  localparam int WAIT_LIMIT = 200;
  localparam int MAX_PKTS   = 32;
  localparam int MAX_FLITS  = 12;

  logic                                    clk;
  logic                                    arst_n;
  noc_pkg::link_t [0:noc_pkg::NUM_PORTS-1] in_link;
  logic [0:noc_pkg::NUM_PORTS-1]           in_en;
  noc_pkg::link_t [0:noc_pkg::NUM_PORTS-1] out_link;
  logic [0:noc_pkg::NUM_PORTS-1]           out_en;

  // Every packet ever built, indexed by the tag carried in its head flit
  noc_pkg::flit_u pkt_flits [0:MAX_PKTS-1][0:MAX_FLITS-1];
  logic [15:0]    pkt_pay   [0:MAX_PKTS-1][0:MAX_FLITS-1];
  int             pkt_len   [0:MAX_PKTS-1];
  int             pkt_dest  [0:MAX_PKTS-1];
  bit             seen      [0:MAX_PKTS-1];
  int             pkt_cnt;

  // Flits seen on each output, and flits handed to each input
  noc_pkg::flit_u out_q [0:noc_pkg::NUM_PORTS-1][$];
  int             sent_cnt [0:noc_pkg::NUM_PORTS-1];
  int             seed;
  int             errors;

  noc_router_top u_dut (
    .clk        (clk),
    .i_arst_n   (arst_n),
    .i_in_link  (in_link),
    .o_in_en    (in_en),
    .o_out_link (out_link),
    .i_out_en   (out_en)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Output links are registered, so at the falling edge they are stable
  always @(negedge clk) begin
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      if (out_link[j].valid) begin
        out_q[j].push_back(out_link[j].flit);
      end
    end
  end

  // ------------------------------------------------------------
  // Packet building, driving and checking
  // ------------------------------------------------------------

  // Head carries dest and the packet number as tag, then bodies, then a tail
  task automatic make_packet(input int dest, input int n_body, output int id);
    noc_pkg::flit_u f;
    int k;
    id = pkt_cnt;
    pkt_cnt++;
    pkt_dest[id] = dest;
    pkt_len[id]  = n_body + 2;
    seen[id]     = 1'b0;
    f = '0;
    f.head.kind = noc_pkg::KIND_HEAD;
    f.head.dest = noc_pkg::PORT_W'(dest);
    f.head.tag  = noc_pkg::TAG_W'(id);
    pkt_flits[id][0] = f;
    for (k = 1; k < pkt_len[id]; k++) begin
      f.body.kind    = (k == pkt_len[id] - 1) ? noc_pkg::KIND_TAIL : noc_pkg::KIND_BODY;
      f.body.payload = 16'($random(seed));
      pkt_pay[id][k]   = f.body.payload;
      pkt_flits[id][k] = f;
    end
  endtask

  // One flit per falling edge, and valid only while the enable is seen high
  task automatic send_packet(input int port, input int id);
    int k;
    int t;
    for (k = 0; k < pkt_len[id]; k++) begin
      @(negedge clk);
      t = 0;
      while (!in_en[port] && t < WAIT_LIMIT) begin
        in_link[port].valid = 1'b0;
        @(negedge clk);
        t++;
      end
      if (!in_en[port]) begin
        $display("Input %0d enable stayed low too long while sending packet %0d", port, id);
        errors++;
        in_link[port].valid = 1'b0;
        return;
      end
      in_link[port].valid = 1'b1;
      in_link[port].flit  = pkt_flits[id][k];
      sent_cnt[port]++;
    end
    @(negedge clk);
    in_link[port].valid = 1'b0;
  endtask

  // Waits until every output has collected all flits of the packets from first_id on
  task automatic wait_delivery(input int first_id);
    int  need [0:noc_pkg::NUM_PORTS-1];
    int  p;
    int  t;
    bit  done;
    for (p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      need[p] = 0;
    end
    for (p = first_id; p < pkt_cnt; p++) begin
      need[pkt_dest[p]] += pkt_len[p];
    end
    t = 0;
    do begin
      @(posedge clk);
      t++;
      done = 1'b1;
      for (p = 0; p < noc_pkg::NUM_PORTS; p++) begin
        if (out_q[p].size() < need[p]) begin
          done = 1'b0;
        end
      end
    end while (!done && t < WAIT_LIMIT);
    assert (done) else begin
      $display("Timed out waiting for packets to leave the router");
      errors++;
    end
    // A short margin lets any stray extra flit show up in the queues
    repeat (3) @(posedge clk);
  endtask

  // The output stream must split into whole expected packets, each seen once
  task automatic compare_output(input int port, input int first_id);
    noc_pkg::flit_u got;
    noc_pkg::flit_u want;
    int pos;
    int id;
    int k;
    int want_pkts;
    int got_pkts;
    bit head_ok;
    want_pkts = 0;
    for (k = first_id; k < pkt_cnt; k++) begin
      if (pkt_dest[k] == port) begin
        want_pkts++;
      end
    end
    pos      = 0;
    got_pkts = 0;
    while (pos < out_q[port].size()) begin
      got = out_q[port][pos];
      id  = int'(got.head.tag);
      head_ok = (got.head.kind == noc_pkg::KIND_HEAD) && id >= first_id && id < pkt_cnt;
      if (head_ok) begin
        head_ok = (pkt_dest[id] == port) && !seen[id];
      end
      assert (head_ok) else begin
        $display("Output %0d carried a flit that does not start an expected packet", port);
        errors++;
      end
      if (!head_ok) break;
      seen[id] = 1'b1;
      assert (pos + pkt_len[id] <= out_q[port].size()) else begin
        $display("Packet %0d on output %0d is missing flits", id, port);
        errors++;
      end
      if (pos + pkt_len[id] > out_q[port].size()) break;
      for (k = 0; k < pkt_len[id]; k++) begin
        got  = out_q[port][pos + k];
        want = pkt_flits[id][k];
        assert (got == want) else begin
          $display("FAIL o_out_link[%0d].flit got %h expected %h", port, got, want);
          errors++;
        end
        // Payload read back through the body view of the same word
        if (k > 0) begin
          assert (got.body.payload == pkt_pay[id][k]) else begin
            $display("FAIL o_out_link[%0d].flit.body.payload got %h expected %h",
                     port, got.body.payload, pkt_pay[id][k]);
            errors++;
          end
        end
      end
      pos += pkt_len[id];
      got_pkts++;
    end
    assert (got_pkts == want_pkts) else begin
      $display("Output %0d delivered %0d packets instead of %0d", port, got_pkts, want_pkts);
      errors++;
    end
    out_q[port].delete();
  endtask

  task automatic compare_all_outputs(input int first_id);
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      compare_output(j, first_id);
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic check_reset_state();
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      assert (!out_link[j].valid) else begin
        $display("FAIL o_out_link[%0d].valid got %h expected 0", j, out_link[j].valid);
        errors++;
      end
      assert (in_en[j]) else begin
        $display("FAIL o_in_en[%0d] got %h expected 1", j, in_en[j]);
        errors++;
      end
    end
  endtask

  task automatic send_single_packet();
    int first;
    int id;
    first = pkt_cnt;
    make_packet(2, 3, id);
    send_packet(0, id);
    wait_delivery(first);
    compare_all_outputs(first);
  endtask

  // Input i goes to output i+1, so no two packets share an output
  task automatic send_parallel_packets();
    int first;
    int id0;
    int id1;
    int id2;
    int id3;
    first = pkt_cnt;
    make_packet(1, 1, id0);
    make_packet(2, 2, id1);
    make_packet(3, 0, id2);
    make_packet(0, 3, id3);
    fork
      send_packet(0, id0);
      send_packet(1, id1);
      send_packet(2, id2);
      send_packet(3, id3);
    join
    wait_delivery(first);
    compare_all_outputs(first);
  endtask

  // Three inputs fight for output 2 with multi-flit packets
  task automatic send_contending_packets();
    int first;
    int id0;
    int id1;
    int id3;
    first = pkt_cnt;
    make_packet(2, 4, id0);
    make_packet(2, 3, id1);
    make_packet(2, 5, id3);
    fork
      send_packet(0, id0);
      send_packet(1, id1);
      send_packet(3, id3);
    join
    wait_delivery(first);
    compare_all_outputs(first);
  endtask

  // Output 2 is disabled mid-packet until input 1 backs up to a full FIFO
  task automatic apply_back_pressure();
    int first;
    int id;
    int t;
    int n0;
    int n1;
    first = pkt_cnt;
    make_packet(2, 8, id);
    sent_cnt[1] = 0;
    fork
      send_packet(1, id);
      begin
        t = 0;
        do begin
          @(posedge clk);
          t++;
        end while (out_q[2].size() < 2 && t < WAIT_LIMIT);
        assert (out_q[2].size() >= 2) else begin
          $display("Output 2 did not start delivering the packet before the timeout");
          errors++;
        end
        n0 = out_q[2].size();
        @(negedge clk);
        out_en[2] = 1'b0;
        t = 0;
        do begin
          @(negedge clk);
          t++;
        end while (in_en[1] && t < WAIT_LIMIT);
        assert (!in_en[1]) else begin
          $display("Input 1 enable never dropped while output 2 was disabled");
          errors++;
        end
        repeat (3) @(posedge clk);
        n1 = out_q[2].size();
        assert (n1 - n0 <= 1) else begin
          $display("FAIL o_out_link[2].valid flits after disable got %h expected at most 1",
                   n1 - n0);
          errors++;
        end
        // The flits held back must be exactly one full input FIFO
        assert (sent_cnt[1] - n1 == noc_pkg::FIFO_DEPTH) else begin
          $display("FAIL o_in_en[1] dropped with %h flits buffered, expected %h",
                   sent_cnt[1] - n1, noc_pkg::FIFO_DEPTH);
          errors++;
        end
        @(negedge clk);
        out_en[2] = 1'b1;
      end
    join
    wait_delivery(first);
    compare_all_outputs(first);
  endtask

  initial begin
    seed     = 50;
    errors   = 0;
    pkt_cnt  = 0;
    arst_n   = 1'b0;
    in_link  = '0;
    out_en   = '1;
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      sent_cnt[p] = 0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_reset_state();
    send_single_packet();
    send_parallel_packets();
    send_contending_packets();
    apply_back_pressure();
    $display("Simulation finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== source/noc_router_top.sv ====
/*
  Top level of the four-port wormhole router. Links carry a valid flag and
  a flit, and each direction has an enable for flow control.
*/

`timescale 1ns/100ps

module noc_router_top (
  input  logic                                    clk,
  input  logic                                    i_arst_n,
  // Upstream side, one link and one enable per input port
  input  noc_pkg::link_t [0:noc_pkg::NUM_PORTS-1] i_in_link,
  output logic [0:noc_pkg::NUM_PORTS-1]           o_in_en,
  // Downstream side, one link and one enable per output port
  output noc_pkg::link_t [0:noc_pkg::NUM_PORTS-1] o_out_link,
  input  logic [0:noc_pkg::NUM_PORTS-1]           i_out_en
);

  // Per input, its one-hot output request
  logic [0:noc_pkg::NUM_PORTS-1][0:noc_pkg::NUM_PORTS-1] in_req;
  // Per input, the head flit is the end of its packet
  logic [0:noc_pkg::NUM_PORTS-1]                         in_is_tail;
  // Per input, pop the FIFO head
  logic [0:noc_pkg::NUM_PORTS-1]                         rd_grant;
  // Per input, the flit waiting at the FIFO head
  noc_pkg::flit_u [0:noc_pkg::NUM_PORTS-1]               head_flit;
  // Per output, which input it takes its flit from
  logic [0:noc_pkg::NUM_PORTS-1][0:noc_pkg::NUM_PORTS-1] out_grant;

  // ----------------------------------------------------------
  // Input units
  // ----------------------------------------------------------

  genvar i;
  generate
    for (i = 0; i < noc_pkg::NUM_PORTS; i++) begin : gen_in_unit
      noc_input_unit u_in_unit (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_link      (i_in_link[i]),
        .o_en        (o_in_en[i]),
        .i_rd_grant  (rd_grant[i]),
        .o_req       (in_req[i]),
        .o_head_flit (head_flit[i]),
        .o_is_tail   (in_is_tail[i])
      );
    end
  endgenerate

  // ----------------------------------------------------------
  // Arbitration and switching
  // ----------------------------------------------------------

  // Grants are combinational, so a fresh head flit can win in the cycle it arrives
  noc_switch_control u_switch_control (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_req       (in_req),
    .i_is_tail   (in_is_tail),
    .i_out_en    (i_out_en),
    .o_out_grant (out_grant),
    .o_rd_grant  (rd_grant)
  );

  // The crossbar adds the single register stage before the output links
  noc_crossbar u_crossbar (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_flit      (head_flit),
    .i_out_grant (out_grant),
    .o_link      (o_out_link)
  );

endmodule

// ==== source/noc_crossbar.sv ====
/*
  Crossbar for the router. Routes each input head flit to the output that
  granted it and registers the result onto the output links.
*/

`timescale 1ns/100ps

module noc_crossbar (
  input  logic                                                 clk,
  input  logic                                                 i_arst_n,
  input  noc_pkg::flit_u [0:noc_pkg::NUM_PORTS-1]               i_flit,
  input  logic [0:noc_pkg::NUM_PORTS-1][0:noc_pkg::NUM_PORTS-1] i_out_grant,
  output noc_pkg::link_t [0:noc_pkg::NUM_PORTS-1]               o_link
);

  noc_pkg::flit_u [0:noc_pkg::NUM_PORTS-1] sel_flit;
  noc_pkg::flit_u [0:noc_pkg::NUM_PORTS-1] flit_q;
  logic [0:noc_pkg::NUM_PORTS-1]           valid_q;

  // Grants are one-hot per output, so at most one input matches
  always_comb begin
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      sel_flit[j] = '0;
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (i_out_grant[j][i]) begin
          sel_flit[j] = i_flit[i];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------

  // A flit is valid on the link the cycle after its output was granted
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= '0;
    end else begin
      for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
        valid_q[j] <= |i_out_grant[j];
      end
    end
  end

  // Flit data only loads when there is something to send
  always_ff @(posedge clk) begin
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      if (|i_out_grant[j]) begin
        flit_q[j] <= sel_flit[j];
      end
    end
  end

  always_comb begin
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      o_link[j].valid = valid_q[j];
      o_link[j].flit  = flit_q[j];
    end
  end

endmodule

// ==== source/noc_switch_control.sv ====
/*
  Switch controller for the crossbar. Masks input requests with the
  downstream enables, arbitrates each output round-robin and tells each
  input unit when its head flit is taken.
*/

`timescale 1ns/100ps

module noc_switch_control (
  input  logic                                                 clk,
  input  logic                                                 i_arst_n,
  // Per input, the one-hot output it wants
  input  logic [0:noc_pkg::NUM_PORTS-1][0:noc_pkg::NUM_PORTS-1] i_req,
  // Per input, whether its head flit is the last of the packet
  input  logic [0:noc_pkg::NUM_PORTS-1]                         i_is_tail,
  // Per output, whether the downstream router can take a flit
  input  logic [0:noc_pkg::NUM_PORTS-1]                         i_out_en,
  // Per output, the one-hot input it is granted to
  output logic [0:noc_pkg::NUM_PORTS-1][0:noc_pkg::NUM_PORTS-1] o_out_grant,
  // Per input, pop the FIFO head on this edge
  output logic [0:noc_pkg::NUM_PORTS-1]                         o_rd_grant
);

  // Requests seen from the output side, already masked by the enables
  logic [0:noc_pkg::NUM_PORTS-1][0:noc_pkg::NUM_PORTS-1] out_req;
  // Per output, the granted flit closes the packet
  logic [0:noc_pkg::NUM_PORTS-1]                         release_out;

  // ----------------------------------------------------------
  // Request transpose and masking
  // ----------------------------------------------------------

  // Row i of the input matrix belongs to input i, row j of out_req to output j
  // A disabled output sees no requests at all, so it never grants and its lock stays put
  always_comb begin
    out_req = '0;
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        out_req[j][i] = i_req[i][j] && i_out_en[j];
      end
    end
  end

  // ----------------------------------------------------------
  // One arbiter per output
  // ----------------------------------------------------------

  // The lock is released when the winner's current flit is a tail
  always_comb begin
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      release_out[j] = |(o_out_grant[j] & i_is_tail);
    end
  end

  genvar j;
  generate
    for (j = 0; j < noc_pkg::NUM_PORTS; j++) begin : gen_out_arb
      noc_rr_arbiter u_arb (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_req     (out_req[j]),
        .i_release (release_out[j]),
        .o_grant   (o_out_grant[j])
      );
    end
  endgenerate

  // ----------------------------------------------------------
  // Read grants back to the input units
  // ----------------------------------------------------------

  // Each input asks for one output only, so at most one output grant
  // can name a given input and a plain OR over outputs is enough
  always_comb begin
    o_rd_grant = '0;
    for (int k = 0; k < noc_pkg::NUM_PORTS; k++) begin
      o_rd_grant |= o_out_grant[k];
    end
  end

endmodule

// ==== source/noc_rr_arbiter.sv ====
/*
  Round-robin arbiter for one router output. The winner keeps the output
  until the tail flit is granted, then priority moves one past it.
*/

`timescale 1ns/100ps

module noc_rr_arbiter (
  input  logic                            clk,
  input  logic                            i_arst_n,
  input  logic [0:noc_pkg::NUM_PORTS-1]   i_req,
  input  logic                            i_release,
  output logic [0:noc_pkg::NUM_PORTS-1]   o_grant
);

  logic                          lock_q;
  logic [noc_pkg::PORT_W-1:0]    ptr_q;
  logic [noc_pkg::PORT_W-1:0]    owner_q;
  logic [noc_pkg::PORT_W-1:0]    winner;
  logic [noc_pkg::PORT_W-1:0]    idx;
  logic                          found;

  // While locked only the owner can win, and only when it requests
  // Otherwise the first requester at or after the pointer wins
  always_comb begin
    o_grant = '0;
    winner  = owner_q;
    idx     = '0;
    found   = 1'b0;
    if (lock_q) begin
      o_grant[owner_q] = i_req[owner_q];
    end else begin
      for (int k = 0; k < noc_pkg::NUM_PORTS; k++) begin
        idx = noc_pkg::PORT_W'((int'(ptr_q) + k) % noc_pkg::NUM_PORTS);
        if (!found && i_req[idx]) begin
          found  = 1'b1;
          winner = idx;
        end
      end
      if (found) begin
        o_grant[winner] = 1'b1;
      end
    end
  end

  // Lock and pointer only move on a cycle that actually grants
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lock_q  <= 1'b0;
      ptr_q   <= '0;
      owner_q <= '0;
    end else if (|o_grant) begin
      if (i_release) begin
        lock_q <= 1'b0;
        ptr_q  <= noc_pkg::PORT_W'((int'(winner) + 1) % noc_pkg::NUM_PORTS);
      end else if (!lock_q) begin
        // First flit of a packet claims the output
        lock_q  <= 1'b1;
        owner_q <= winner;
      end
    end
  end

endmodule

// ==== source/noc_input_unit.sv ====
/*
  Input unit of one router port. Buffers incoming flits in a small FIFO,
  decodes the head flit into a one-hot output request and holds that route
  until the tail flit of the packet has been read out by the switch.
*/

`timescale 1ns/100ps

module noc_input_unit (
  input  logic                               clk,
  input  logic                               i_arst_n,
  input  noc_pkg::link_t                     i_link,
  output logic                               o_en,
  input  logic                               i_rd_grant,
  output logic [0:noc_pkg::NUM_PORTS-1]      o_req,
  output noc_pkg::flit_u                     o_head_flit,
  output logic                               o_is_tail
);

  noc_pkg::flit_u                   mem [noc_pkg::FIFO_DEPTH];
  logic [noc_pkg::PTR_W-1:0]        wr_ptr_q;
  logic [noc_pkg::PTR_W-1:0]        rd_ptr_q;
  logic [noc_pkg::CNT_W-1:0]        count_q;
  logic                             wr;
  logic                             rd;
  logic                             not_empty;
  logic [0:noc_pkg::NUM_PORTS-1]    head_dec;
  logic [0:noc_pkg::NUM_PORTS-1]    route_q;
  logic                             route_vld_q;

  // ----------------------------------------------------------
  // FIFO storage and pointers
  // ----------------------------------------------------------

  // Upstream may only send while the enable is high, so a full FIFO stops it
  assign o_en      = (count_q != noc_pkg::CNT_W'(noc_pkg::FIFO_DEPTH));
  assign not_empty = (count_q != '0);
  assign wr        = i_link.valid && o_en;
  // The switch only grants a port that requests, but an empty pop is still ignored
  assign rd        = i_rd_grant && not_empty;

  // Flit storage, written at the slot named by the write pointer
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr_q] <= i_link.flit;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr) begin
        wr_ptr_q <= (wr_ptr_q == noc_pkg::PTR_W'(noc_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::PTR_W'(noc_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      case ({wr, rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign o_head_flit = mem[rd_ptr_q];

  // ----------------------------------------------------------
  // Route decode and hold
  // ----------------------------------------------------------

  // One-hot decode of the destination, valid only when a head flit waits at the front
  always_comb begin
    head_dec = '0;
    if (o_head_flit.head.kind == noc_pkg::KIND_HEAD) begin
      head_dec[o_head_flit.head.dest] = 1'b1;
    end
  end

  // The route is captured as the head flit leaves and dropped as the tail leaves
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      route_vld_q <= 1'b0;
      route_q     <= '0;
    end else if (rd) begin
      if (o_head_flit.head.kind == noc_pkg::KIND_HEAD) begin
        route_vld_q <= 1'b1;
        route_q     <= head_dec;
      end else if (o_is_tail) begin
        route_vld_q <= 1'b0;
      end
    end
  end

  // A new head requests at once, later flits reuse the held route
  // Nothing is requested while the FIFO is empty so that no empty slot is ever granted
  always_comb begin
    o_req = '0;
    if (not_empty) begin
      o_req = route_vld_q ? route_q : head_dec;
    end
  end

  // The tail flag lets the arbiter release its lock on the last grant
  assign o_is_tail = not_empty && (o_head_flit.body.kind == noc_pkg::KIND_TAIL);

endmodule

// ==== source/noc_pkg.sv ====
/*
  Shared constants and types for the four-port wormhole router.
  Every router file refers to these through scoped names.
*/

package noc_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------

  // Number of input ports, and also of output ports
  localparam int NUM_PORTS  = 4;

  // Bits needed to name one port
  localparam int PORT_W     = 2;

  // Flit slots in each input FIFO
  localparam int FIFO_DEPTH = 4;

  // FIFO pointer width and occupancy counter width
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // Data bits carried by every flit, next to the kind field
  localparam int FLIT_W     = 16;

  // A head flit spends PORT_W of its data bits on the destination
  localparam int TAG_W      = FLIT_W - PORT_W;

  // ----------------------------------------------------------
  // Flit layout
  // ----------------------------------------------------------

  // A one-flit packet is sent as a head followed directly by a tail
  typedef enum logic [1:0] {
    KIND_HEAD = 2'd0,
    KIND_BODY = 2'd1,
    KIND_TAIL = 2'd2
  } flit_kind_e;

  // Head flit: the destination output sits in the top data bits
  typedef struct packed {
    flit_kind_e          kind;
    logic [PORT_W-1:0]   dest;
    logic [TAG_W-1:0]    tag;
  } head_view_t;

  // Body and tail flits carry plain payload
  typedef struct packed {
    flit_kind_e          kind;
    logic [FLIT_W-1:0]   payload;
  } body_view_t;

  // One flit word, seen either as a head or as a body flit
  typedef union packed {
    head_view_t head;
    body_view_t body;
  } flit_u;

  // What travels on every link, in and out of the router
  typedef struct packed {
    logic  valid;
    flit_u flit;
  } link_t;

endpackage
